/* src/lsq_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Load/store queue definitions
// Widths, queue sizes, memory opcodes and the instruction and bus encodings
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package lsq_pkg;

	localparam int DATA_W   = 64;
	localparam int PRF_SIZE = 64;
	localparam int ROB_SIZE = 32;
	localparam int LQ_SIZE  = 8;
	localparam int SQ_SIZE  = 8;

	localparam int LQ_IDX_W = $clog2(LQ_SIZE);
	localparam int SQ_IDX_W = $clog2(SQ_SIZE);

	typedef logic [DATA_W-1:0]           data_t;
	typedef logic [$clog2(PRF_SIZE)-1:0] prf_tag_t;
	typedef logic [$clog2(ROB_SIZE)-1:0] rob_idx_t;
	typedef logic [LQ_IDX_W:0]           lq_ptr_t;	// Top bit is the wrap bit
	typedef logic [SQ_IDX_W:0]           sq_ptr_t;

	// Alpha memory opcodes
	localparam logic [5:0] OP_LDQ   = 6'h29;
	localparam logic [5:0] OP_LDQ_L = 6'h2b;
	localparam logic [5:0] OP_STQ   = 6'h2d;
	localparam logic [5:0] OP_STQ_C = 6'h2f;

	typedef enum logic [1:0] {
		NO_INST,
		IS_LOAD,
		IS_STORE
	} mem_inst_t;

	// Command on the memory bus
	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_LOAD,
		MEM_STORE
	} mem_cmd_t;

endpackage

`default_nettype wire

/* src/lsq_dispatch.sv */
////////////////////////////////////////////////////////////////////////////
// LSQ dispatch
// Decodes the memory instruction, bypasses the CDB into waiting operands
// and steers the instruction to the load or the store queue
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module lsq_dispatch
	import lsq_pkg::*;
(
	input  wire logic     clock,
	input  wire logic     reset,
	input  wire logic     inst_valid,
	input  wire logic [5:0] op_type,
	input  wire data_t    opa,
	input  wire data_t    opb,
	input  wire logic     opb_valid,
	input  wire data_t    store_data,
	input  wire logic     store_data_valid,
	input  wire prf_tag_t dest_tag,
	input  wire rob_idx_t rob_idx,
	input  wire logic     cdb_in_valid,
	input  wire prf_tag_t cdb_in_tag,
	input  wire data_t    cdb_in_data,
	input  wire logic     lq_count_full,
	input  wire logic     sq_count_full,
	output logic          lq_alloc,
	output logic          sq_alloc,
	output data_t         alloc_opb,
	output logic          alloc_opb_valid,
	output data_t         alloc_data,
	output logic          alloc_data_valid,
	output logic          lsq_full
);

	mem_inst_t inst_type;
	logic      opb_hit;
	logic      data_hit;

	always_comb begin
		case (op_type)
			OP_LDQ, OP_LDQ_L: inst_type = IS_LOAD;	// Locked forms act as plain ones
			OP_STQ, OP_STQ_C: inst_type = IS_STORE;
			default:          inst_type = NO_INST;
		endcase
	end

	assign lq_alloc = inst_valid && (inst_type == IS_LOAD);
	assign sq_alloc = inst_valid && (inst_type == IS_STORE);

	// While not valid, the low bits of the operand hold the producer tag
	assign opb_hit  = !opb_valid && cdb_in_valid && (cdb_in_tag == prf_tag_t'(opb));
	assign data_hit = !store_data_valid && cdb_in_valid
		&& (cdb_in_tag == prf_tag_t'(store_data));

	assign alloc_opb        = opb_hit ? cdb_in_data : opb;
	assign alloc_opb_valid  = opb_valid || opb_hit;
	assign alloc_data       = data_hit ? cdb_in_data : store_data;
	assign alloc_data_valid = store_data_valid || data_hit;

	assign lsq_full = lq_count_full || sq_count_full;	// Either queue stalls rename

	// Rename holds off while either queue is full
	assert property (@(posedge clock) disable iff (reset)
		(lq_alloc || sq_alloc) |-> !lsq_full)
		else $error("lsq_dispatch: allocation while full");

endmodule

`default_nettype wire

/* src/load_queue.sv */
////////////////////////////////////////////////////////////////////////////
// Load queue
// Circular queue of loads that wake up from the CDB and issue from the
// head in program order, once every older store has written memory
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module load_queue
	import lsq_pkg::*;
(
	input  wire logic     clock,
	input  wire logic     reset,
	input  wire logic     flush,
	input  wire logic     lq_alloc,
	input  wire data_t    opa,
	input  wire data_t    alloc_opb,
	input  wire logic     alloc_opb_valid,
	input  wire prf_tag_t dest_tag,
	input  wire rob_idx_t rob_idx,
	input  wire logic     cdb_in_valid,
	input  wire prf_tag_t cdb_in_tag,
	input  wire data_t    cdb_in_data,
	input  wire sq_ptr_t  sq_tail_ptr,
	input  wire sq_ptr_t  sq_head_ptr,
	input  wire logic     load_grant,
	input  wire logic     load_data_valid,
	output logic          load_req,
	output data_t         load_address,
	output prf_tag_t      head_tag,
	output rob_idx_t      head_rob_idx,
	output logic          lq_count_full
);

	data_t    opa_q  [LQ_SIZE];
	data_t    opb_q  [LQ_SIZE];
	prf_tag_t tag_q  [LQ_SIZE];
	rob_idx_t rob_q  [LQ_SIZE];
	sq_ptr_t  snap_q [LQ_SIZE];	// Store tail seen at dispatch
	logic [LQ_SIZE-1:0] opb_v_q;
	logic [LQ_SIZE-1:0] issued_q;
	logic [LQ_SIZE-1:0] opb_wake;

	lq_ptr_t head;
	lq_ptr_t tail;
	logic [LQ_IDX_W-1:0] head_idx;
	logic [LQ_IDX_W-1:0] tail_idx;
	logic empty;

	assign head_idx      = head[LQ_IDX_W-1:0];
	assign tail_idx      = tail[LQ_IDX_W-1:0];
	assign empty         = (head == tail);
	assign lq_count_full = (head_idx == tail_idx) && (head[LQ_IDX_W] != tail[LQ_IDX_W]);

	always_comb begin
		for (int i = 0; i < LQ_SIZE; i++) begin
			opb_wake[i] = !opb_v_q[i] && cdb_in_valid && (cdb_in_tag == prf_tag_t'(opb_q[i]));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Head issue
	////////////////////////////////////////////////////////////////////////////

	assign load_req = !empty && opb_v_q[head_idx] && !issued_q[head_idx]
		&& (sq_head_ptr == snap_q[head_idx]);	// Older stores all drained
	assign load_address = opa_q[head_idx] + opb_q[head_idx];
	assign head_tag     = tag_q[head_idx];
	assign head_rob_idx = rob_q[head_idx];

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			head <= '0;
			tail <= '0;
		end else begin
			if (lq_alloc)
				tail <= tail + 1'b1;
			if (load_data_valid)
				head <= head + 1'b1;	// Pop when the data comes back
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			opb_v_q  <= '0;
			issued_q <= '0;
		end else begin
			for (int i = 0; i < LQ_SIZE; i++) begin
				if (lq_alloc && tail_idx == LQ_IDX_W'(i)) begin
					opb_v_q[i]  <= alloc_opb_valid;
					issued_q[i] <= 1'b0;
				end else if (opb_wake[i]) begin
					opb_v_q[i] <= 1'b1;
				end
			end
			if (load_grant)
				issued_q[head_idx] <= 1'b1;
		end
	end

	// Entry payload
	always_ff @(posedge clock) begin
		for (int i = 0; i < LQ_SIZE; i++) begin
			if (lq_alloc && tail_idx == LQ_IDX_W'(i)) begin
				opa_q[i]  <= opa;
				opb_q[i]  <= alloc_opb;
				tag_q[i]  <= dest_tag;
				rob_q[i]  <= rob_idx;
				snap_q[i] <= sq_tail_ptr;
			end else if (opb_wake[i]) begin
				opb_q[i] <= cdb_in_data;
			end
		end
	end

	// Memory data only ever answers the head load that was sent
	assert property (@(posedge clock) disable iff (reset)
		load_data_valid |-> !empty && issued_q[head_idx])
		else $error("load_queue: load data without an issued head");

endmodule

`default_nettype wire

/* src/store_queue.sv */
////////////////////////////////////////////////////////////////////////////
// Store queue
// Stores wake up from the CDB, broadcast their address once ready, and
// write memory from the head when the reorder buffer reaches them
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module store_queue
	import lsq_pkg::*;
(
	input  wire logic     clock,
	input  wire logic     reset,
	input  wire logic     flush,
	input  wire logic     sq_alloc,
	input  wire data_t    opa,
	input  wire data_t    alloc_opb,
	input  wire logic     alloc_opb_valid,
	input  wire data_t    alloc_data,
	input  wire logic     alloc_data_valid,
	input  wire prf_tag_t dest_tag,
	input  wire rob_idx_t rob_idx,
	input  wire logic     cdb_in_valid,
	input  wire prf_tag_t cdb_in_tag,
	input  wire data_t    cdb_in_data,
	input  wire rob_idx_t rob_head,
	input  wire logic     done_ack,
	input  wire logic     store_grant,
	output logic          done_req,
	output prf_tag_t      done_tag,
	output rob_idx_t      done_rob_idx,
	output data_t         done_address,
	output logic          store_req,
	output data_t         store_address,
	output data_t         store_data,
	output sq_ptr_t       sq_tail_ptr,
	output sq_ptr_t       sq_head_ptr,
	output logic          sq_count_full
);

	data_t    opa_q  [SQ_SIZE];
	data_t    opb_q  [SQ_SIZE];
	data_t    data_q [SQ_SIZE];
	prf_tag_t tag_q  [SQ_SIZE];
	rob_idx_t rob_q  [SQ_SIZE];
	logic [SQ_SIZE-1:0] opb_v_q;
	logic [SQ_SIZE-1:0] data_v_q;
	logic [SQ_SIZE-1:0] completed_q;	// Address already broadcast
	logic [SQ_SIZE-1:0] opb_wake;
	logic [SQ_SIZE-1:0] data_wake;

	sq_ptr_t head;
	sq_ptr_t tail;
	sq_ptr_t occupancy;
	logic [SQ_IDX_W-1:0] head_idx;
	logic [SQ_IDX_W-1:0] tail_idx;
	logic [SQ_IDX_W-1:0] done_idx;
	logic empty;

	assign head_idx      = head[SQ_IDX_W-1:0];
	assign tail_idx      = tail[SQ_IDX_W-1:0];
	assign occupancy     = tail - head;
	assign empty         = (head == tail);
	assign sq_count_full = (head_idx == tail_idx) && (head[SQ_IDX_W] != tail[SQ_IDX_W]);
	assign sq_head_ptr   = head;
	assign sq_tail_ptr   = tail;

	always_comb begin
		for (int i = 0; i < SQ_SIZE; i++) begin
			opb_wake[i]  = !opb_v_q[i] && cdb_in_valid && (cdb_in_tag == prf_tag_t'(opb_q[i]));
			data_wake[i] = !data_v_q[i] && cdb_in_valid
				&& (cdb_in_tag == prf_tag_t'(data_q[i]));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Completion and commit requests
	////////////////////////////////////////////////////////////////////////////

	// Oldest entry with both operands that has not broadcast yet
	always_comb begin
		done_req = 1'b0;
		done_idx = head_idx;
		for (int i = 0; i < SQ_SIZE; i++) begin
			if (!done_req && sq_ptr_t'(i) < occupancy
				&& opb_v_q[head_idx + SQ_IDX_W'(i)] && data_v_q[head_idx + SQ_IDX_W'(i)]
				&& !completed_q[head_idx + SQ_IDX_W'(i)]) begin
				done_req = 1'b1;
				done_idx = head_idx + SQ_IDX_W'(i);
			end
		end
	end

	assign done_tag     = tag_q[done_idx];
	assign done_rob_idx = rob_q[done_idx];
	assign done_address = opa_q[done_idx] + opb_q[done_idx];

	assign store_req     = !empty && completed_q[head_idx] && (rob_head == rob_q[head_idx]);
	assign store_address = opa_q[head_idx] + opb_q[head_idx];
	assign store_data    = data_q[head_idx];

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			head <= '0;
			tail <= '0;
		end else begin
			if (sq_alloc)
				tail <= tail + 1'b1;
			if (store_grant)
				head <= head + 1'b1;	// Leaves once memory took it
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			opb_v_q     <= '0;
			data_v_q    <= '0;
			completed_q <= '0;
		end else begin
			for (int i = 0; i < SQ_SIZE; i++) begin
				if (sq_alloc && tail_idx == SQ_IDX_W'(i)) begin
					opb_v_q[i]     <= alloc_opb_valid;
					data_v_q[i]    <= alloc_data_valid;
					completed_q[i] <= 1'b0;
				end else begin
					if (opb_wake[i])
						opb_v_q[i] <= 1'b1;
					if (data_wake[i])
						data_v_q[i] <= 1'b1;
					if (done_ack && done_idx == SQ_IDX_W'(i))
						completed_q[i] <= 1'b1;
				end
			end
		end
	end

	// Entry payload
	always_ff @(posedge clock) begin
		for (int i = 0; i < SQ_SIZE; i++) begin
			if (sq_alloc && tail_idx == SQ_IDX_W'(i)) begin
				opa_q[i]  <= opa;
				opb_q[i]  <= alloc_opb;
				data_q[i] <= alloc_data;
				tag_q[i]  <= dest_tag;
				rob_q[i]  <= rob_idx;
			end else begin
				if (opb_wake[i])
					opb_q[i] <= cdb_in_data;
				if (data_wake[i])
					data_q[i] <= cdb_in_data;
			end
		end
	end

	// A store reaches memory only after its completion went out
	assert property (@(posedge clock) disable iff (reset)
		store_grant |-> !empty && completed_q[head_idx])
		else $error("store_queue: commit granted before completion");

endmodule

`default_nettype wire

/* src/lsq_mem_arbiter.sv */
////////////////////////////////////////////////////////////////////////////
// Memory bus arbiter
// Committing stores win over loads; at most one load is in flight
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module lsq_mem_arbiter
	import lsq_pkg::*;
(
	input  wire logic  clock,
	input  wire logic  reset,
	input  wire logic  flush,
	input  wire logic  store_req,
	input  wire data_t store_address,
	input  wire data_t store_data,
	input  wire logic  load_req,
	input  wire data_t load_address,
	input  wire logic  mem_ready,
	input  wire logic  mem_rvalid,
	input  wire data_t mem_rdata,
	output mem_cmd_t   mem_command,
	output data_t      mem_address,
	output data_t      mem_wdata,
	output logic       store_grant,
	output logic       load_grant,
	output logic       load_data_valid,
	output data_t      load_data
);

	logic outstanding;	// Load sent, response pending
	logic discard;	// Pending response belongs to a flushed load
	logic load_ok;

	assign load_ok = load_req && !store_req && !outstanding && !discard;

	always_comb begin
		if (store_req)
			mem_command = MEM_STORE;
		else if (load_ok)
			mem_command = MEM_LOAD;
		else
			mem_command = MEM_NONE;
	end

	assign mem_address = store_req ? store_address : load_address;
	assign mem_wdata   = store_data;

	assign store_grant = store_req && mem_ready;
	assign load_grant  = load_ok && mem_ready;

	assign load_data_valid = mem_rvalid && outstanding;
	assign load_data       = mem_rdata;

	always_ff @(posedge clock) begin
		if (reset) begin
			outstanding <= 1'b0;
			discard     <= 1'b0;
		end else if (flush) begin
			outstanding <= 1'b0;
			discard     <= ((outstanding || discard) && !mem_rvalid) || load_grant;
		end else begin
			if (load_grant)
				outstanding <= 1'b1;
			else if (mem_rvalid)
				outstanding <= 1'b0;
			if (mem_rvalid)
				discard <= 1'b0;
		end
	end

	// Memory answers only loads that were sent
	assert property (@(posedge clock) disable iff (reset)
		mem_rvalid |-> outstanding || discard)
		else $error("lsq_mem_arbiter: response with no load in flight");

endmodule

`default_nettype wire

/* src/lsq_result_out.sv */
////////////////////////////////////////////////////////////////////////////
// LSQ result output
// Registers one CDB result per cycle, load data first, store completion
// only when no load data arrives
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module lsq_result_out
	import lsq_pkg::*;
(
	input  wire logic     clock,
	input  wire logic     reset,
	input  wire logic     load_data_valid,
	input  wire data_t    load_data,
	input  wire prf_tag_t head_tag,
	input  wire rob_idx_t head_rob_idx,
	input  wire logic     done_req,
	input  wire prf_tag_t done_tag,
	input  wire rob_idx_t done_rob_idx,
	input  wire data_t    done_address,
	output logic          done_ack,
	output logic          cdb_out_valid,
	output prf_tag_t      cdb_out_tag,
	output data_t         cdb_out_data,
	output rob_idx_t      cdb_out_rob_idx
);

	assign done_ack = done_req && !load_data_valid;	// Store waits behind load data

	always_ff @(posedge clock) begin
		if (reset)
			cdb_out_valid <= 1'b0;
		else
			cdb_out_valid <= load_data_valid || done_req;
	end

	always_ff @(posedge clock) begin
		if (load_data_valid) begin
			cdb_out_tag     <= head_tag;
			cdb_out_data    <= load_data;
			cdb_out_rob_idx <= head_rob_idx;
		end else if (done_req) begin
			cdb_out_tag     <= done_tag;
			cdb_out_data    <= done_address;	// Stores report their address
			cdb_out_rob_idx <= done_rob_idx;
		end
	end

endmodule

`default_nettype wire

/* src/lsq_top.sv */
////////////////////////////////////////////////////////////////////////////
// Load/store queue top level
// Dispatch, load and store queues, memory arbiter and CDB output
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module lsq_top
	import lsq_pkg::*;
(
	input  wire logic     clock,
	input  wire logic     reset,
	input  wire logic     inst_valid,
	input  wire logic [5:0] op_type,
	input  wire data_t    opa,
	input  wire data_t    opb,
	input  wire logic     opb_valid,
	input  wire data_t    store_data,
	input  wire logic     store_data_valid,
	input  wire prf_tag_t dest_tag,
	input  wire rob_idx_t rob_idx,
	input  wire logic     cdb_in_valid,
	input  wire prf_tag_t cdb_in_tag,
	input  wire data_t    cdb_in_data,
	input  wire rob_idx_t rob_head,
	input  wire logic     flush,
	output mem_cmd_t      mem_command,
	output data_t         mem_address,
	output data_t         mem_wdata,
	input  wire logic     mem_ready,
	input  wire logic     mem_rvalid,
	input  wire data_t    mem_rdata,
	output logic          cdb_out_valid,
	output prf_tag_t      cdb_out_tag,
	output data_t         cdb_out_data,
	output rob_idx_t      cdb_out_rob_idx,
	output logic          lsq_full
);

	// Dispatch to queues
	logic     lq_alloc;
	logic     sq_alloc;
	data_t    alloc_opb;
	logic     alloc_opb_valid;
	data_t    alloc_data;
	logic     alloc_data_valid;
	logic     lq_count_full;
	logic     sq_count_full;

	// Queues to arbiter and output
	logic     load_req;
	data_t    load_address;
	prf_tag_t head_tag;
	rob_idx_t head_rob_idx;
	logic     done_req;
	logic     done_ack;
	prf_tag_t done_tag;
	rob_idx_t done_rob_idx;
	data_t    done_address;
	logic     store_req;
	data_t    store_address;
	data_t    store_wdata;
	sq_ptr_t  sq_tail_ptr;
	sq_ptr_t  sq_head_ptr;

	// Arbiter back to queues
	logic     store_grant;
	logic     load_grant;
	logic     load_data_valid;
	data_t    load_data;

	lsq_dispatch lsq_dispatch_i (
		.clock, .reset, .inst_valid, .op_type, .opa, .opb, .opb_valid,
		.store_data, .store_data_valid, .dest_tag, .rob_idx,
		.cdb_in_valid, .cdb_in_tag, .cdb_in_data, .lq_count_full, .sq_count_full,
		.lq_alloc, .sq_alloc, .alloc_opb, .alloc_opb_valid,
		.alloc_data, .alloc_data_valid, .lsq_full
	);

	load_queue load_queue_i (
		.clock, .reset, .flush, .lq_alloc, .opa, .alloc_opb, .alloc_opb_valid,
		.dest_tag, .rob_idx, .cdb_in_valid, .cdb_in_tag, .cdb_in_data,
		.sq_tail_ptr, .sq_head_ptr, .load_grant, .load_data_valid,
		.load_req, .load_address, .head_tag, .head_rob_idx, .lq_count_full
	);

	store_queue store_queue_i (
		.clock, .reset, .flush, .sq_alloc, .opa, .alloc_opb, .alloc_opb_valid,
		.alloc_data, .alloc_data_valid, .dest_tag, .rob_idx,
		.cdb_in_valid, .cdb_in_tag, .cdb_in_data, .rob_head, .done_ack, .store_grant,
		.done_req, .done_tag, .done_rob_idx, .done_address,
		.store_req, .store_address, .store_data(store_wdata),
		.sq_tail_ptr, .sq_head_ptr, .sq_count_full
	);

	lsq_mem_arbiter lsq_mem_arbiter_i (
		.clock, .reset, .flush, .store_req, .store_address, .store_data(store_wdata),
		.load_req, .load_address, .mem_ready, .mem_rvalid, .mem_rdata,
		.mem_command, .mem_address, .mem_wdata, .store_grant, .load_grant,
		.load_data_valid, .load_data
	);

	lsq_result_out lsq_result_out_i (
		.clock, .reset, .load_data_valid, .load_data, .head_tag, .head_rob_idx,
		.done_req, .done_tag, .done_rob_idx, .done_address, .done_ack,
		.cdb_out_valid, .cdb_out_tag, .cdb_out_data, .cdb_out_rob_idx
	);

endmodule

`default_nettype wire

/* sim/lsq_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Load/store queue testbench
// Directed tests against a small memory model with random ready and
// random load latency
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module lsq_tb
	import lsq_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam time PERIOD        = 100;
	localparam int  WAIT_LIMIT    = 60;
	localparam int  NUM_OPS       = 40;	// Dispatches, waits and idle windows over all tests
	localparam int  MAX_OP_CYCLES = 60;

	logic clock;
	logic reset;
	logic inst_valid;
	logic [5:0] op_type;
	data_t opa;
	data_t opb;
	logic opb_valid;
	data_t store_data;
	logic store_data_valid;
	prf_tag_t dest_tag;
	rob_idx_t rob_idx;
	logic cdb_in_valid;
	prf_tag_t cdb_in_tag;
	data_t cdb_in_data;
	rob_idx_t rob_head;
	logic flush;
	mem_cmd_t mem_command;
	data_t mem_address;
	data_t mem_wdata;
	logic mem_ready;
	logic mem_rvalid;
	data_t mem_rdata;
	logic cdb_out_valid;
	prf_tag_t cdb_out_tag;
	data_t cdb_out_data;
	rob_idx_t cdb_out_rob_idx;
	logic lsq_full;

	lsq_top lsq_top_i (.*);

	////////////////////////////////////////////////////////////////////////////
	// Memory model
	////////////////////////////////////////////////////////////////////////////

	data_t mem_array [256];
	logic [7:0] rd_idx;
	logic [31:0] lcg_state = 32'h0d0b_4b6d;
	int load_issues = 0;	// Loads taken by memory
	int served = 0;	// Responses returned
	int store_writes = 0;
	int resp_wait = 0;
	int force_latency = 0;	// Nonzero pins the load latency
	bit counting = 0;
	time last_rvalid_time = 0;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic data_t fill_word(input int idx);
		return {~(32'(idx) * 32'h9e37_79b9), 32'(idx) ^ 32'h1357_2468};
	endfunction

	function automatic data_t expected_load(input data_t addr);
		return fill_word(int'(addr[10:3]));
	endfunction

	always @(posedge clock) begin
		if (!reset && mem_ready) begin
			if (mem_command == MEM_STORE) begin
				mem_array[mem_address[10:3]] <= mem_wdata;
				store_writes <= store_writes + 1;
			end else if (mem_command == MEM_LOAD) begin
				rd_idx      <= mem_address[10:3];
				load_issues <= load_issues + 1;
			end
		end
	end

	always @(negedge clock) begin
		lcg_state = lcg_next(lcg_state);
		mem_ready <= (lcg_state[17:16] != 2'b00);
		mem_rvalid <= 1'b0;
		if (served != load_issues) begin
			if (!counting) begin
				counting = 1;
				resp_wait = (force_latency != 0) ? force_latency
					: 1 + int'(lcg_state[25:24]) % 3;
			end
			resp_wait = resp_wait - 1;
			if (resp_wait == 0) begin
				mem_rvalid <= 1'b1;
				mem_rdata <= mem_array[rd_idx];
				served = served + 1;
				counting = 0;
				last_rvalid_time = $time;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Failure reporting and compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("TESTS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic fail_plain(input string msg);
		$display("error at %0t: %s", $time, msg);
		abort_run();
	endtask

	task automatic check_data(input data_t got, input data_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_tag(input prf_tag_t got, input prf_tag_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_rob(input rob_idx_t got, input rob_idx_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_cmd(input mem_cmd_t got, input mem_cmd_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %s expected %s", $time, what, got.name(),
				exp.name());
			abort_run();
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Drive and wait helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic dispatch_inst(input logic [5:0] op, input data_t a, input data_t b,
		input logic b_v, input data_t sd, input logic sd_v, input prf_tag_t tag,
		input rob_idx_t rob);
		@(negedge clock);
		if (lsq_full)
			fail_plain("dispatch attempted while lsq_full is high");
		inst_valid       = 1'b1;
		op_type          = op;
		opa              = a;
		opb              = b;
		opb_valid        = b_v;
		store_data       = sd;
		store_data_valid = sd_v;
		dest_tag         = tag;
		rob_idx          = rob;
	endtask

	task automatic release_inputs();
		@(negedge clock);
		inst_valid   = 1'b0;
		cdb_in_valid = 1'b0;
		flush        = 1'b0;
	endtask

	task automatic set_rob_head(input rob_idx_t head);
		@(negedge clock);
		rob_head = head;
	endtask

	// Returns at the falling edge where a CDB result is visible
	task automatic wait_cdb(input bit load_timing);
		int n;
		n = 0;
		@(negedge clock);
		while (!cdb_out_valid) begin
			if (n == WAIT_LIMIT)
				fail_plain("no CDB result appeared in time");
			n++;
			@(negedge clock);
		end
		if (load_timing && ($time - last_rvalid_time != PERIOD))
			fail_plain("load result did not follow the memory response by one cycle");
	endtask

	task automatic expect_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge clock);
			#1;
			check_bit(cdb_out_valid, 1'b0, "cdb_out_valid while idle");
			check_cmd(mem_command, MEM_NONE, "mem_command while idle");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset();
		@(negedge clock);
		#1;
		check_bit(cdb_out_valid, 1'b0, "cdb_out_valid after reset");
		check_cmd(mem_command, MEM_NONE, "mem_command after reset");
		check_bit(lsq_full, 1'b0, "lsq_full after reset");
	endtask

	task automatic test_ready_load();
		dispatch_inst(OP_LDQ, 64'h100, 64'h28, 1'b1, '0, 1'b0, 6'd1, 5'd1);
		release_inputs();
		wait_cdb(1'b1);
		check_data(cdb_out_data, expected_load(64'h128), "ready load data");
		check_tag(cdb_out_tag, 6'd1, "ready load tag");
		check_rob(cdb_out_rob_idx, 5'd1, "ready load rob index");
		@(negedge clock);
		check_bit(cdb_out_valid, 1'b0, "second CDB result for one load");
	endtask

	task automatic test_waiting_operand();
		dispatch_inst(OP_LDQ, 64'h500, 64'd21, 1'b0, '0, 1'b0, 6'd10, 5'd2);
		release_inputs();
		expect_quiet(4);
		@(negedge clock);
		cdb_in_valid = 1'b1;
		cdb_in_tag   = 6'd21;
		cdb_in_data  = 64'h30;
		release_inputs();
		wait_cdb(1'b1);
		check_data(cdb_out_data, expected_load(64'h530), "woken load data");
		check_tag(cdb_out_tag, 6'd10, "woken load tag");
		check_rob(cdb_out_rob_idx, 5'd2, "woken load rob index");
		// Tag on the CDB in the dispatch cycle itself
		dispatch_inst(OP_LDQ_L, 64'h600, 64'd22, 1'b0, '0, 1'b0, 6'd11, 5'd3);
		cdb_in_valid = 1'b1;
		cdb_in_tag   = 6'd22;
		cdb_in_data  = 64'h48;
		release_inputs();
		wait_cdb(1'b1);
		check_data(cdb_out_data, expected_load(64'h648), "bypassed load data");
		check_tag(cdb_out_tag, 6'd11, "bypassed load tag");
		check_rob(cdb_out_rob_idx, 5'd3, "bypassed load rob index");
	endtask

	task automatic test_store_commit();
		int writes_before;
		writes_before = store_writes;
		dispatch_inst(OP_STQ, 64'h200, 64'h18, 1'b1, 64'hdead_beef_0123_4567, 1'b1,
			6'd30, 5'd5);
		release_inputs();
		wait_cdb(1'b0);
		check_data(cdb_out_data, 64'h218, "store completion address");
		check_tag(cdb_out_tag, 6'd30, "store completion tag");
		check_rob(cdb_out_rob_idx, 5'd5, "store completion rob index");
		expect_quiet(4);
		// Younger load to the same word waits for the commit
		dispatch_inst(OP_LDQ, 64'h210, 64'h8, 1'b1, '0, 1'b0, 6'd31, 5'd6);
		release_inputs();
		expect_quiet(4);
		if (store_writes != writes_before)
			fail_plain("store wrote memory before reaching the ROB head");
		set_rob_head(5'd5);
		wait_cdb(1'b1);
		check_data(cdb_out_data, 64'hdead_beef_0123_4567, "load after store data");
		check_tag(cdb_out_tag, 6'd31, "load after store tag");
		check_rob(cdb_out_rob_idx, 5'd6, "load after store rob index");
		if (store_writes != writes_before + 1)
			fail_plain("store did not write memory exactly once");
		check_data(mem_array[8'h43], 64'hdead_beef_0123_4567, "memory after commit");
	endtask

	task automatic test_full();
		int n;
		set_rob_head(5'd0);
		for (int i = 0; i < SQ_SIZE; i++) begin
			dispatch_inst(OP_STQ, 64'h300, data_t'(8 * i), 1'b1,
				64'h5000_0000_0000_0000 + data_t'(i), 1'b1, prf_tag_t'(40 + i),
				rob_idx_t'(8 + i));
			release_inputs();
		end
		#1;
		check_bit(lsq_full, 1'b1, "lsq_full with eight stores");
		set_rob_head(5'd8);
		n = 0;
		while (lsq_full) begin
			if (n == WAIT_LIMIT)
				fail_plain("lsq_full stayed high after the head store could commit");
			n++;
			@(negedge clock);
		end
		set_rob_head(5'd0);
		check_data(mem_array[8'h60], 64'h5000_0000_0000_0000, "first committed store");
	endtask

	task automatic test_flush();
		int writes_before;
		int issues_before;
		int n;
		// One more store fills the queue again
		dispatch_inst(OP_STQ, 64'h300, 64'h40, 1'b1, 64'h5000_0000_0000_0008, 1'b1,
			6'd48, 5'd16);
		release_inputs();
		#1;
		check_bit(lsq_full, 1'b1, "lsq_full before flush");
		@(negedge clock);
		flush = 1'b1;
		release_inputs();
		#1;
		check_bit(lsq_full, 1'b0, "lsq_full after flush");
		writes_before = store_writes;
		set_rob_head(5'd9);	// Oldest flushed store would match here
		force_latency = 3;
		issues_before = load_issues;
		dispatch_inst(OP_LDQ, 64'h400, 64'h8, 1'b1, '0, 1'b0, 6'd50, 5'd20);
		release_inputs();
		n = 0;
		while (load_issues == issues_before) begin
			if (n == WAIT_LIMIT)
				fail_plain("load was never sent to memory");
			n++;
			@(negedge clock);
		end
		flush = 1'b1;
		release_inputs();
		expect_quiet(8);
		force_latency = 0;
		if (store_writes != writes_before)
			fail_plain("flushed store wrote memory");
		for (int i = 1; i <= SQ_SIZE; i++)
			check_data(mem_array[8'h60 + i], fill_word(8'h60 + i), "memory after flush");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Clock, watchdog and sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(NUM_OPS * MAX_OP_CYCLES * PERIOD);
		fail_plain("watchdog expired before the tests finished");
	end

	initial begin
		for (int i = 0; i < 256; i++)
			mem_array[i] = fill_word(i);
		reset = 1'b1;
		inst_valid = 1'b0;
		op_type = '0;
		opa = '0;
		opb = '0;
		opb_valid = 1'b0;
		store_data = '0;
		store_data_valid = 1'b0;
		dest_tag = '0;
		rob_idx = '0;
		cdb_in_valid = 1'b0;
		cdb_in_tag = '0;
		cdb_in_data = '0;
		rob_head = '0;
		flush = 1'b0;
		mem_ready = 1'b1;
		mem_rvalid = 1'b0;
		mem_rdata = '0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		test_reset();
		test_ready_load();
		test_waiting_operand();
		test_store_commit();
		test_full();
		test_flush();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
src/lsq_pkg.sv
src/lsq_dispatch.sv
src/load_queue.sv
src/store_queue.sv
src/lsq_mem_arbiter.sv
src/lsq_result_out.sv
src/lsq_top.sv
sim/lsq_tb.sv

/* Bender.yml */
package:
  name: lsq

sources:
  - src/lsq_pkg.sv
  - src/lsq_dispatch.sv
  - src/load_queue.sv
  - src/store_queue.sv
  - src/lsq_mem_arbiter.sv
  - src/lsq_result_out.sv
  - src/lsq_top.sv
  - target: simulation
    files:
      - sim/lsq_tb.sv
